// File: source/tracer_pkg.sv
/* commit tracer shared types */

package tracer_pkg;

    localparam int xlen = 64;          // register and data width
    localparam int ilen = 32;          // instruction word width
    localparam int csr_addr_w = 12;
    localparam int gpr_addr_w = 6;     // logical rd incl. fp bank bit
    localparam int strb_w = 8;         // one strobe bit per data byte
    localparam int size_w = 4;         // counts 0 to 8 bytes
    localparam int priv_w = 2;

    // register, csr, address and data values
    typedef logic [xlen-1:0] xlen_t;

    // raw instruction word
    typedef logic [ilen-1:0] inst_t;

    typedef logic [csr_addr_w-1:0] csr_addr_t;

    typedef logic [gpr_addr_w-1:0] gpr_addr_t;

    // byte enables of a store
    typedef logic [strb_w-1:0] strb_t;

    // bytes written by a store
    typedef logic [size_w-1:0] size_t;

    typedef logic [priv_w-1:0] priv_t;

    // supervisor csrs that shadow machine csrs
    localparam csr_addr_t csr_sstatus = 12'h100;
    localparam csr_addr_t csr_sie = 12'h104;
    localparam csr_addr_t csr_sip = 12'h144;

    // s-level to m-level distance in csr space
    localparam csr_addr_t csr_s_to_m_offset = 12'h200;

    // user counter window, time sits in between
    localparam csr_addr_t csr_cycle = 12'hc00;
    localparam csr_addr_t csr_instret = 12'hc02;

    // user counter to mcycle/minstret distance
    localparam csr_addr_t csr_u_to_m_offset = 12'h100;

endpackage

// File: source/csr_snap_if.sv
/* csr snapshot lookup */

`timescale 1ns/1ps

interface csr_snap_if #(
    parameter int op_id_width = 7
);
    logic [op_id_width-1:0] op_id;     // id of the committing op
    tracer_pkg::xlen_t      mstatus;
    tracer_pkg::xlen_t      mtvec;
    tracer_pkg::xlen_t      mepc;
    tracer_pkg::xlen_t      mcause;

    // snapshot memory side
    modport tbl (
        input  op_id,
        output mstatus, mtvec, mepc, mcause
    );

    // commit stage side
    modport reader (
        output op_id,
        input  mstatus, mtvec, mepc, mcause
    );

endinterface

// File: source/csr_snap_table.sv
/* csr snapshot table */

`timescale 1ns/1ps

module csr_snap_table #(
    parameter int op_id_width = 7
)(
    input  logic                   clk,
    input  logic                   dec_valid,    // op decoded this cycle
    input  logic [op_id_width-1:0] dec_op_id,
    input  tracer_pkg::xlen_t      mstatus,      // live csr values at decode
    input  tracer_pkg::xlen_t      mtvec,
    input  tracer_pkg::xlen_t      mepc,
    input  tracer_pkg::xlen_t      mcause,
    csr_snap_if.tbl                snap
);

    localparam int depth = 2 ** op_id_width;

    // one entry per in-flight op id
    tracer_pkg::xlen_t mstatus_mem [depth];
    tracer_pkg::xlen_t mtvec_mem   [depth];
    tracer_pkg::xlen_t mepc_mem    [depth];
    tracer_pkg::xlen_t mcause_mem  [depth];

    // the csrs seen at decode describe the state before this op runs,
    // so they are what the commit record has to show
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            mstatus_mem[dec_op_id] <= mstatus;
            mtvec_mem[dec_op_id]   <= mtvec;
            mepc_mem[dec_op_id]    <= mepc;
            mcause_mem[dec_op_id]  <= mcause;
        end
    end

    // async read, same-cycle write lands after the edge
    always_comb begin
        snap.mstatus = mstatus_mem[snap.op_id];
        snap.mtvec   = mtvec_mem[snap.op_id];
        snap.mepc    = mepc_mem[snap.op_id];
        snap.mcause  = mcause_mem[snap.op_id];
    end

endmodule

// File: source/store_tracker.sv
/* store request tracker */

`timescale 1ns/1ps

module store_tracker #(
    parameter int store_tag_width = 4
)(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       st_req,       // dcache store request
    input  logic [store_tag_width-1:0] st_req_tag,
    input  tracer_pkg::xlen_t          st_addr,
    input  tracer_pkg::xlen_t          st_data,
    input  tracer_pkg::strb_t          st_strb,
    input  logic                       st_resp,      // store completed
    input  logic [store_tag_width-1:0] st_resp_tag,
    output tracer_pkg::size_t          mem_w,        // bytes written, 0 when idle
    output tracer_pkg::xlen_t          mem_addr,
    output tracer_pkg::xlen_t          mem_data
);

    localparam int depth = 2 ** store_tag_width;
    localparam int offs_w = $clog2(tracer_pkg::strb_w);

    tracer_pkg::xlen_t addr_mem [depth];
    tracer_pkg::xlen_t data_mem [depth];
    tracer_pkg::size_t size_mem [depth];

    logic [offs_w-1:0] lsb_idx;        // lowest enabled byte lane
    tracer_pkg::xlen_t data_aligned;
    tracer_pkg::size_t req_size;

    always_comb begin
        lsb_idx = '0;
        for (int i = tracer_pkg::strb_w - 1; i >= 0; i--) begin
            if (st_strb[i]) lsb_idx = offs_w'(i);
        end
    end

    // move the written bytes down to bit 0
    assign data_aligned = st_data >> {lsb_idx, 3'b000};
    assign req_size = tracer_pkg::size_t'($countones(st_strb));

    always_ff @(posedge clk) begin
        if (st_req) begin
            addr_mem[st_req_tag] <= st_addr;
            data_mem[st_req_tag] <= data_aligned;
            size_mem[st_req_tag] <= req_size;
        end
    end

    // response reads the entry as it was before this edge
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_w <= '0;
        end else if (st_resp) begin
            mem_w <= size_mem[st_resp_tag];
        end else begin
            mem_w <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (st_resp) begin
            mem_addr <= addr_mem[st_resp_tag];
            mem_data <= data_mem[st_resp_tag];
        end
    end

endmodule

// File: source/commit_trace.sv
/* commit record stage */

`timescale 1ns/1ps

module commit_trace #(
    parameter int op_id_width = 7
)(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cmt_valid,     // one lane retires
    input  logic [op_id_width-1:0]  cmt_op_id,
    input  tracer_pkg::xlen_t       cmt_pc,
    input  tracer_pkg::inst_t       cmt_ir,
    input  tracer_pkg::gpr_addr_t   cmt_rd,
    input  tracer_pkg::priv_t       cmt_level,
    input  logic                    csr_we,
    input  tracer_pkg::csr_addr_t   csr_addr,
    input  tracer_pkg::xlen_t       csr_wdata,
    input  logic                    trap_taken,
    input  logic                    trap_to_s,     // trap delegated to s-mode
    csr_snap_if.reader              snap,
    output logic                    trace_valid,
    output tracer_pkg::xlen_t       trace_pc,
    output tracer_pkg::inst_t       trace_ir,
    output tracer_pkg::gpr_addr_t   trace_rd,
    output logic                    trace_gpr,     // rd written
    output tracer_pkg::priv_t       trace_level,
    output tracer_pkg::xlen_t       trace_mstatus,
    output tracer_pkg::xlen_t       trace_mtvec,
    output tracer_pkg::xlen_t       trace_mepc,
    output tracer_pkg::xlen_t       trace_mcause,
    output logic                    csr_w,
    output tracer_pkg::csr_addr_t   csr_a,
    output tracer_pkg::xlen_t       csr_v,
    output logic                    trap_m,
    output logic                    trap_s
);

    tracer_pkg::csr_addr_t csr_a_alias;

    assign snap.op_id = cmt_op_id;     // look up snapshot of the retiring op

    // report writes under the machine-level name the reference model uses
    always_comb begin
        csr_a_alias = csr_addr;
        if (csr_addr == tracer_pkg::csr_sstatus || csr_addr == tracer_pkg::csr_sie ||
            csr_addr == tracer_pkg::csr_sip) begin
            csr_a_alias = csr_addr + tracer_pkg::csr_s_to_m_offset;
        end else if (csr_addr >= tracer_pkg::csr_cycle &&
                     csr_addr <= tracer_pkg::csr_instret) begin
            csr_a_alias = csr_addr - tracer_pkg::csr_u_to_m_offset;   // cycle, time, instret
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            trace_valid <= 1'b0;
            csr_w       <= 1'b0;
            trap_m      <= 1'b0;
            trap_s      <= 1'b0;
        end else begin
            trace_valid <= cmt_valid;
            csr_w       <= csr_we;
            trap_m      <= trap_taken & ~trap_to_s;
            trap_s      <= trap_taken & trap_to_s;
        end
    end

    // commit payload
    always_ff @(posedge clk) begin
        if (cmt_valid) begin
            trace_pc      <= cmt_pc;
            trace_ir      <= cmt_ir;
            trace_rd      <= cmt_rd;
            trace_gpr     <= |cmt_rd;    // x0 is never a real write
            trace_level   <= cmt_level;
            trace_mstatus <= snap.mstatus;
            trace_mtvec   <= snap.mtvec;
            trace_mepc    <= snap.mepc;
            trace_mcause  <= snap.mcause;
        end
    end

    always_ff @(posedge clk) begin
        if (csr_we) begin
            csr_a <= csr_a_alias;
            csr_v <= csr_wdata;
        end
    end

endmodule

// File: source/vcore_tracer.sv
/* commit trace extractor top */

`timescale 1ns/1ps

module vcore_tracer #(
    parameter int op_id_width = 7,
    parameter int store_tag_width = 4
)(
    input  logic                       clk,
    input  logic                       rst,
    // decode side
    input  logic                       dec_valid,
    input  logic [op_id_width-1:0]     dec_op_id,
    input  tracer_pkg::xlen_t          dec_mstatus,
    input  tracer_pkg::xlen_t          dec_mtvec,
    input  tracer_pkg::xlen_t          dec_mepc,
    input  tracer_pkg::xlen_t          dec_mcause,
    // commit lane
    input  logic                       cmt_valid,
    input  logic [op_id_width-1:0]     cmt_op_id,
    input  tracer_pkg::xlen_t          cmt_pc,
    input  tracer_pkg::inst_t          cmt_ir,
    input  tracer_pkg::gpr_addr_t      cmt_rd,
    input  tracer_pkg::priv_t          cmt_level,
    input  logic                       csr_we,
    input  tracer_pkg::csr_addr_t      csr_addr,
    input  tracer_pkg::xlen_t          csr_wdata,
    input  logic                       trap_taken,
    input  logic                       trap_to_s,
    // dcache stores
    input  logic                       st_req,
    input  logic [store_tag_width-1:0] st_req_tag,
    input  tracer_pkg::xlen_t          st_addr,
    input  tracer_pkg::xlen_t          st_data,
    input  tracer_pkg::strb_t          st_strb,
    input  logic                       st_resp,
    input  logic [store_tag_width-1:0] st_resp_tag,
    // trace out
    output logic                       trace_valid,
    output tracer_pkg::xlen_t          trace_pc,
    output tracer_pkg::inst_t          trace_ir,
    output tracer_pkg::gpr_addr_t      trace_rd,
    output logic                       trace_gpr,
    output tracer_pkg::priv_t          trace_level,
    output tracer_pkg::xlen_t          trace_mstatus,
    output tracer_pkg::xlen_t          trace_mtvec,
    output tracer_pkg::xlen_t          trace_mepc,
    output tracer_pkg::xlen_t          trace_mcause,
    output logic                       csr_w,
    output tracer_pkg::csr_addr_t      csr_a,
    output tracer_pkg::xlen_t          csr_v,
    output logic                       trap_m,
    output logic                       trap_s,
    output tracer_pkg::size_t          mem_w,
    output tracer_pkg::xlen_t          mem_addr,
    output tracer_pkg::xlen_t          mem_data
);

    csr_snap_if #(.op_id_width(op_id_width)) snap_bus ();

    csr_snap_table #(.op_id_width(op_id_width)) u_snap_table (
        .clk(clk), .dec_valid(dec_valid), .dec_op_id(dec_op_id),
        .mstatus(dec_mstatus), .mtvec(dec_mtvec), .mepc(dec_mepc), .mcause(dec_mcause),
        .snap(snap_bus)
    );

    store_tracker #(.store_tag_width(store_tag_width)) u_store_tracker (
        .clk(clk), .rst(rst),
        .st_req(st_req), .st_req_tag(st_req_tag), .st_addr(st_addr),
        .st_data(st_data), .st_strb(st_strb),
        .st_resp(st_resp), .st_resp_tag(st_resp_tag),
        .mem_w(mem_w), .mem_addr(mem_addr), .mem_data(mem_data)
    );

    commit_trace #(.op_id_width(op_id_width)) u_commit_trace (
        .clk(clk), .rst(rst),
        .cmt_valid(cmt_valid), .cmt_op_id(cmt_op_id), .cmt_pc(cmt_pc), .cmt_ir(cmt_ir),
        .cmt_rd(cmt_rd), .cmt_level(cmt_level),
        .csr_we(csr_we), .csr_addr(csr_addr), .csr_wdata(csr_wdata),
        .trap_taken(trap_taken), .trap_to_s(trap_to_s),
        .snap(snap_bus),
        .trace_valid(trace_valid), .trace_pc(trace_pc), .trace_ir(trace_ir),
        .trace_rd(trace_rd), .trace_gpr(trace_gpr), .trace_level(trace_level),
        .trace_mstatus(trace_mstatus), .trace_mtvec(trace_mtvec),
        .trace_mepc(trace_mepc), .trace_mcause(trace_mcause),
        .csr_w(csr_w), .csr_a(csr_a), .csr_v(csr_v),
        .trap_m(trap_m), .trap_s(trap_s)
    );

endmodule

// File: testbench/tracer_chk.sv
/* tracer output assertions */

`timescale 1ns/1ps

module tracer_chk (
    input logic                  clk,
    input logic                  rst,
    input logic                  trace_valid,
    input logic                  csr_w,
    input tracer_pkg::csr_addr_t csr_a,
    input logic                  trap_m,
    input logic                  trap_s,
    input tracer_pkg::size_t     mem_w
);

    // all strobes quiet once reset has been seen
    assert property (@(posedge clk) rst |=> (!trace_valid && !csr_w && !trap_m && !trap_s &&
                                             mem_w == '0))
        else $error("outputs active in the cycle after reset");

    // s and u aliases must already be renamed
    assert property (@(posedge clk) disable iff (rst)
        csr_w |-> !(csr_a == 12'h100 || csr_a == 12'h104 || csr_a == 12'h144 ||
                    (csr_a >= 12'hc00 && csr_a <= 12'hc02)))
        else $error("csr write reported under an unaliased address %h", csr_a);

    assert property (@(posedge clk) disable iff (rst) !(trap_m && trap_s))
        else $error("trap_m and trap_s raised together");

endmodule

bind vcore_tracer tracer_chk u_tracer_chk (
    .clk(clk), .rst(rst), .trace_valid(trace_valid), .csr_w(csr_w), .csr_a(csr_a),
    .trap_m(trap_m), .trap_s(trap_s), .mem_w(mem_w)
);

// File: testbench/tb_vcore_tracer.sv
/* commit tracer testbench */

`timescale 1ns/1ps

module tb_vcore_tracer;

    localparam int op_id_width = 7;
    localparam int store_tag_width = 4;
    localparam int test_cycles = 38;                   // reset plus all directed tests
    localparam int timeout_ns = test_cycles * 8 + 200;

    logic clk;
    logic rst;
    logic dec_valid;
    logic [op_id_width-1:0] dec_op_id;
    tracer_pkg::xlen_t dec_mstatus, dec_mtvec, dec_mepc, dec_mcause;
    logic cmt_valid;
    logic [op_id_width-1:0] cmt_op_id;
    tracer_pkg::xlen_t cmt_pc;
    tracer_pkg::inst_t cmt_ir;
    tracer_pkg::gpr_addr_t cmt_rd;
    tracer_pkg::priv_t cmt_level;
    logic csr_we;
    tracer_pkg::csr_addr_t csr_addr;
    tracer_pkg::xlen_t csr_wdata;
    logic trap_taken, trap_to_s;
    logic st_req, st_resp;
    logic [store_tag_width-1:0] st_req_tag, st_resp_tag;
    tracer_pkg::xlen_t st_addr, st_data;
    tracer_pkg::strb_t st_strb;
    logic trace_valid, trace_gpr, csr_w, trap_m, trap_s;
    tracer_pkg::xlen_t trace_pc, trace_mstatus, trace_mtvec, trace_mepc, trace_mcause;
    tracer_pkg::inst_t trace_ir;
    tracer_pkg::gpr_addr_t trace_rd;
    tracer_pkg::priv_t trace_level;
    tracer_pkg::csr_addr_t csr_a;
    tracer_pkg::xlen_t csr_v, mem_addr, mem_data;
    tracer_pkg::size_t mem_w;

    int checks = 0;
    int errors = 0;
    logic [31:0] lfsr_state = 32'd82;

    vcore_tracer #(.op_id_width(op_id_width), .store_tag_width(store_tag_width)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // galois lfsr for x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_next_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic tracer_pkg::xlen_t rand_value(input int nbits);
        tracer_pkg::xlen_t v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            v = {v[62:0], lfsr_next_bit()};
        end
        return v;
    endfunction

    task automatic tally(input logic ok, input string name, input string got, input string exp);
        checks++;
        if (!ok) begin
            errors++;
            $display("FAIL %0t %s: got %s expected %s", $time, name, got, exp);
        end
    endtask

    task automatic check_xlen(input string name, input tracer_pkg::xlen_t got, exp);
        tally(got === exp, name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_inst(input string name, input tracer_pkg::inst_t got, exp);
        tally(got === exp, name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_csr_addr(input string name, input tracer_pkg::csr_addr_t got, exp);
        tally(got === exp, name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_size(input string name, input tracer_pkg::size_t got, exp);
        tally(got === exp, name, $sformatf("%0d", got), $sformatf("%0d", exp));
    endtask

    task automatic check_gpr(input string name, input tracer_pkg::gpr_addr_t got, exp);
        tally(got === exp, name, $sformatf("%0d", got), $sformatf("%0d", exp));
    endtask

    task automatic check_priv(input string name, input tracer_pkg::priv_t got, exp);
        tally(got === exp, name, $sformatf("%0d", got), $sformatf("%0d", exp));
    endtask

    task automatic check_bit(input string name, input logic got, exp);
        tally(got === exp, name, $sformatf("%b", got), $sformatf("%b", exp));
    endtask

    task automatic check_idle();
        check_bit("trace_valid", trace_valid, 1'b0);
        check_bit("csr_w", csr_w, 1'b0);
        check_bit("trap_m", trap_m, 1'b0);
        check_bit("trap_s", trap_s, 1'b0);
        check_size("mem_w", mem_w, 4'd0);
    endtask

    task automatic test_reset();
        cmt_valid = 1'b1;                              // live strobes that reset must mask
        csr_we = 1'b1;
        trap_taken = 1'b1;
        st_resp = 1'b1;
        rst = 1'b1;
        for (int i = 0; i < 2; i++) begin
            trap_to_s = (i == 1);
            @(negedge clk);
            check_idle();
        end
        rst = 1'b0;
        cmt_valid = 1'b0;
        csr_we = 1'b0;
        trap_taken = 1'b0;
        trap_to_s = 1'b0;
        st_resp = 1'b0;
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check_idle();
        end
    endtask

    task automatic test_snapshot_commit();
        int ids [4];
        int order [4];
        tracer_pkg::xlen_t ms_e [4];
        tracer_pkg::xlen_t tv_e [4];
        tracer_pkg::xlen_t ep_e [4];
        tracer_pkg::xlen_t mc_e [4];
        int idx;
        ids = '{5, 17, 64, 127};
        order = '{2, 0, 3, 1};
        for (int i = 0; i < 4; i++) begin
            ms_e[i] = rand_value(64);
            tv_e[i] = rand_value(64);
            ep_e[i] = rand_value(64);
            mc_e[i] = rand_value(64);
            dec_valid = 1'b1;
            dec_op_id = op_id_width'(ids[i]);
            dec_mstatus = ms_e[i];
            dec_mtvec = tv_e[i];
            dec_mepc = ep_e[i];
            dec_mcause = mc_e[i];
            @(negedge clk);
        end
        dec_valid = 1'b0;
        for (int i = 0; i < 4; i++) begin
            idx = order[i];
            cmt_valid = 1'b1;
            cmt_op_id = op_id_width'(ids[idx]);
            cmt_pc = rand_value(64);
            cmt_ir = tracer_pkg::inst_t'(rand_value(32));
            cmt_rd = (i == 1) ? '0 : tracer_pkg::gpr_addr_t'(rand_value(6));   // one x0 write
            cmt_level = tracer_pkg::priv_t'(rand_value(2));
            @(negedge clk);
            check_bit("trace_valid", trace_valid, 1'b1);
            check_xlen("trace_pc", trace_pc, cmt_pc);
            check_inst("trace_ir", trace_ir, cmt_ir);
            check_gpr("trace_rd", trace_rd, cmt_rd);
            check_bit("trace_gpr", trace_gpr, cmt_rd != '0);
            check_priv("trace_level", trace_level, cmt_level);
            check_xlen("trace_mstatus", trace_mstatus, ms_e[idx]);
            check_xlen("trace_mtvec", trace_mtvec, tv_e[idx]);
            check_xlen("trace_mepc", trace_mepc, ep_e[idx]);
            check_xlen("trace_mcause", trace_mcause, mc_e[idx]);
        end
        cmt_valid = 1'b0;
        @(negedge clk);
        check_bit("trace_valid", trace_valid, 1'b0);
    endtask

    task automatic test_csr_alias();
        tracer_pkg::csr_addr_t addrs [7];
        tracer_pkg::csr_addr_t exp_a [7];
        addrs = '{12'h100, 12'h104, 12'h144, 12'hc00, 12'hc01, 12'hc02, 12'h341};
        exp_a = '{12'h300, 12'h304, 12'h344, 12'hb00, 12'hb01, 12'hb02, 12'h341};
        for (int i = 0; i < 7; i++) begin
            csr_we = 1'b1;
            csr_addr = addrs[i];
            csr_wdata = rand_value(64);
            @(negedge clk);
            check_bit("csr_w", csr_w, 1'b1);
            check_csr_addr("csr_a", csr_a, exp_a[i]);
            check_xlen("csr_v", csr_v, csr_wdata);
        end
        csr_we = 1'b0;
        @(negedge clk);
        check_bit("csr_w", csr_w, 1'b0);
    endtask

    task automatic test_store_delta();
        logic [store_tag_width-1:0] tags [4];
        tracer_pkg::strb_t strbs [4];
        tracer_pkg::size_t sizes [4];
        int shifts [4];
        int order [4];
        tracer_pkg::xlen_t addr_e [4];
        tracer_pkg::xlen_t data_e [4];
        int idx;
        tags = '{4'd3, 4'd9, 4'd12, 4'd0};
        strbs = '{8'hff, 8'hf0, 8'h0c, 8'h01};
        sizes = '{4'd8, 4'd4, 4'd2, 4'd1};
        shifts = '{0, 32, 16, 0};
        order = '{2, 0, 3, 1};
        for (int i = 0; i < 4; i++) begin
            addr_e[i] = rand_value(64);
            st_data = rand_value(64);
            data_e[i] = st_data >> shifts[i];          // lowest written byte moves to bit 0
            st_req = 1'b1;
            st_req_tag = tags[i];
            st_addr = addr_e[i];
            st_strb = strbs[i];
            @(negedge clk);
        end
        st_req = 1'b0;
        for (int i = 0; i < 4; i++) begin
            idx = order[i];
            st_resp = 1'b1;
            st_resp_tag = tags[idx];
            @(negedge clk);
            check_size("mem_w", mem_w, sizes[idx]);
            check_xlen("mem_addr", mem_addr, addr_e[idx]);
            check_xlen("mem_data", mem_data, data_e[idx]);
        end
        st_resp = 1'b0;
        @(negedge clk);
        check_size("mem_w", mem_w, 4'd0);
    endtask

    task automatic test_traps();
        logic to_s;
        for (int s = 0; s < 2; s++) begin
            to_s = (s == 1);
            trap_taken = 1'b1;
            trap_to_s = to_s;
            @(negedge clk);
            check_bit("trap_m", trap_m, ~to_s);
            check_bit("trap_s", trap_s, to_s);
            trap_taken = 1'b0;
            @(negedge clk);                            // flags last one cycle only
            check_bit("trap_m", trap_m, 1'b0);
            check_bit("trap_s", trap_s, 1'b0);
        end
    endtask

    initial begin
        #(timeout_ns);
        $display("watchdog expired after %0d ns, the tests did not finish", timeout_ns);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        rst = 1'b1;
        dec_valid = 1'b0;
        dec_op_id = '0;
        dec_mstatus = '0;
        dec_mtvec = '0;
        dec_mepc = '0;
        dec_mcause = '0;
        cmt_valid = 1'b0;
        cmt_op_id = '0;
        cmt_pc = '0;
        cmt_ir = '0;
        cmt_rd = '0;
        cmt_level = '0;
        csr_we = 1'b0;
        csr_addr = '0;
        csr_wdata = '0;
        trap_taken = 1'b0;
        trap_to_s = 1'b0;
        st_req = 1'b0;
        st_req_tag = '0;
        st_addr = '0;
        st_data = '0;
        st_strb = '0;
        st_resp = 1'b0;
        st_resp_tag = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_snapshot_commit();
        test_csr_alias();
        test_store_delta();
        test_traps();
        $display("checks run: %0d, mismatches: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: vlog.f
source/tracer_pkg.sv
source/csr_snap_if.sv
source/csr_snap_table.sv
source/store_tracker.sv
source/commit_trace.sv
source/vcore_tracer.sv
testbench/tracer_chk.sv
testbench/tb_vcore_tracer.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_vcore_tracer
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= ** PASS **

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
